//--- Makefile
# Verilator simulation of the branch predictor testbench

VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/bp_pkg.sv
/*
    branch predictor package
    widths, vector types and bus structs shared by the direction predictor
*/

package bp_pkg;

    // --------------------
    // sizes

    // instruction lanes per fetch block
    localparam int FETCH_LANES     = 4;
    localparam int LOG_FETCH_LANES = 2;

    // table rows
    localparam int GBPT_SETS     = 512;
    localparam int LOG_GBPT_SETS = 9;

    // global history length
    localparam int GH_BITS = 9;

    // --------------------
    // vector types

    // instruction address, halfword offset dropped
    typedef logic [37:0] pc38_t;

    // address bits 37:2, one fetch block
    typedef logic [35:0] fetch_idx_t;

    typedef logic [LOG_FETCH_LANES-1:0] fetch_lane_t;
    typedef logic [GH_BITS-1:0]         gh_t;
    typedef logic [8:0]                 asid_t;
    typedef logic [LOG_GBPT_SETS-1:0]   gbpt_idx_t;

    // two-bit counter as {taken, strong}
    // 00 WN (reset default), 01 SN, 10 WT, 11 ST
    typedef logic [1:0] tbc_t;

    // one row, a counter per lane, fits in a byte
    typedef tbc_t [FETCH_LANES-1:0] gbpt_set_t;

    // --------------------
    // bus structs

    typedef struct packed {
        logic       valid;
        fetch_idx_t fetch_idx;
    } pred_req_t;

    typedef struct packed {
        logic                   valid;
        logic [FETCH_LANES-1:0] taken_by_lane;
        gh_t                    gh;
    } pred_resp_t;

    typedef struct packed {
        logic  valid;
        pc38_t pc38;
        gh_t   gh;
        logic  taken;
        logic  mispredict;
    } update_t;

    // lane of an instruction within its fetch block
    function automatic fetch_lane_t fetch_lane_bits(pc38_t pc38);
        fetch_lane_bits = pc38[LOG_FETCH_LANES-1:0];
    endfunction

endpackage

//--- hdl/bram_2r1w.sv
/*
    dual read, single write block RAM
    registered read ports, byte-enabled write, contents cleared on reset
*/

`timescale 1ns/100ps

module bram_2r1w #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 512
) (
    input  logic                     CLK,
    input  logic                     nRST,

    // read port 0
    input  logic                     port0_ren,
    input  logic [$clog2(DEPTH)-1:0] port0_rindex,
    output logic [WIDTH-1:0]         port0_rdata,

    // read port 1
    input  logic                     port1_ren,
    input  logic [$clog2(DEPTH)-1:0] port1_rindex,
    output logic [WIDTH-1:0]         port1_rdata,

    // write port
    input  logic [WIDTH/8-1:0]       wen_byte,
    input  logic [$clog2(DEPTH)-1:0] windex,
    input  logic [WIDTH-1:0]         wdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    // storage array, write lands at the edge so reads see old data
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int b = 0; b < WIDTH/8; b++) begin
                if (wen_byte[b]) begin
                    mem[windex][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // read registers hold their value while the port is idle
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            port0_rdata <= '0;
            port1_rdata <= '0;
        end else begin
            if (port0_ren) begin
                port0_rdata <= mem[port0_rindex];
            end
            if (port1_ren) begin
                port1_rdata <= mem[port1_rindex];
            end
        end
    end

endmodule

//--- hdl/branch_predictor_top.sv
/*
    branch direction predictor top
    joins the history register and the prediction table
*/

`timescale 1ns/100ps

module branch_predictor_top (
    input  logic                 CLK,
    input  logic                 nRST,

    input  bp_pkg::asid_t        arch_asid,

    input  bp_pkg::pred_req_t    pred_req,
    output bp_pkg::pred_resp_t   pred_resp,

    input  bp_pkg::update_t      update
);

    import bp_pkg::*;

    gh_t                    gh;
    logic [FETCH_LANES-1:0] taken_by_lane;
    logic                   resp_valid;
    gh_t                    resp_gh;

    // history keeps the table index in step with predictions
    ghr i_ghr (
        .CLK                (CLK),
        .nRST               (nRST),
        .req_valid          (pred_req.valid),
        .resp_taken_by_lane (taken_by_lane),
        .update             (update),
        .gh                 (gh),
        .resp_valid         (resp_valid),
        .resp_gh            (resp_gh)
    );

    gbpt i_gbpt (
        .CLK                     (CLK),
        .nRST                    (nRST),
        .arch_asid               (arch_asid),
        .read_req_valid          (pred_req.valid),
        .read_req_fetch_index    (pred_req.fetch_idx),
        .read_req_gh             (gh),
        .read_resp_taken_by_lane (taken_by_lane),
        .update_valid            (update.valid),
        .update_pc38             (update.pc38),
        .update_gh               (update.gh),
        .update_taken            (update.taken)
    );

    // response bundle
    assign pred_resp.valid         = resp_valid;
    assign pred_resp.taken_by_lane = taken_by_lane;
    assign pred_resp.gh            = resp_gh;

endmodule

//--- hdl/gbpt.sv
/*
    global branch prediction table
    gshare-style two-bit counters per fetch lane, hashed by index, history and ASID
    update path does read-modify-write with forwarding between back-to-back updates
*/

`timescale 1ns/100ps

module gbpt (
    input  logic                          CLK,
    input  logic                          nRST,

    // architectural state
    input  bp_pkg::asid_t                 arch_asid,

    // read request
    input  logic                          read_req_valid,
    input  bp_pkg::fetch_idx_t            read_req_fetch_index,
    input  bp_pkg::gh_t                   read_req_gh,

    // read response, one cycle after the request
    output logic [bp_pkg::FETCH_LANES-1:0] read_resp_taken_by_lane,

    // resolution update
    input  logic                          update_valid,
    input  bp_pkg::pc38_t                 update_pc38,
    input  bp_pkg::gh_t                   update_gh,
    input  logic                          update_taken
);

    import bp_pkg::*;

    // --------------------
    // helpers

    // row select: low fetch index ^ history ^ asid
    function automatic gbpt_idx_t index_hash(fetch_idx_t fidx, gh_t hist, asid_t asid);
        index_hash = fidx[LOG_GBPT_SETS-1:0] ^ hist ^ asid;
    endfunction

    // saturating counter step, taken bit then strong bit
    function automatic tbc_t tbc_next(tbc_t cur, logic taken);
        if (taken) begin
            // SN only climbs to WN, everything else jumps to ST
            tbc_next = (cur == 2'b01) ? 2'b00 : 2'b11;
        end else begin
            // ST drops to WT, everything else falls to SN
            tbc_next = (cur == 2'b11) ? 2'b10 : 2'b01;
        end
    endfunction

    // --------------------
    // signals

    // read path, port 0
    gbpt_idx_t  rd_index;
    gbpt_set_t  rd_set;

    // update path, port 1
    fetch_idx_t upd_fetch_idx;
    gbpt_idx_t  upd_index;
    gbpt_set_t  upd_ram_set;

    // write stage
    logic       wr_valid;
    gbpt_idx_t  wr_index;
    fetch_lane_t wr_lane;
    logic       wr_taken;
    gbpt_set_t  wr_old_set;
    gbpt_set_t  wr_set;
    logic [$bits(gbpt_set_t)/8-1:0] wr_byten;

    // forwarding of the last written row
    logic       fwd_hit;
    gbpt_set_t  fwd_set;

    // --------------------
    // read path

    assign rd_index = index_hash(read_req_fetch_index, read_req_gh, arch_asid);

    // predict taken on the counter's taken bit
    always_comb begin
        for (int lane = 0; lane < FETCH_LANES; lane++) begin
            read_resp_taken_by_lane[lane] = rd_set[lane][1];
        end
    end

    // --------------------
    // update path

    // lane bits dropped to get the fetch block
    assign upd_fetch_idx = update_pc38[$bits(pc38_t)-1:LOG_FETCH_LANES];
    assign upd_index     = index_hash(upd_fetch_idx, update_gh, arch_asid);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wr_valid <= 1'b0;
            fwd_hit  <= 1'b0;
        end else begin
            wr_valid <= update_valid;
            // next update hits the row being written now
            fwd_hit  <= wr_valid & (upd_index == wr_index);
        end
    end

    always_ff @(posedge CLK) begin
        wr_index <= upd_index;
        wr_lane  <= fetch_lane_bits(update_pc38);
        wr_taken <= update_taken;
        fwd_set  <= wr_set;
    end

    // ram still holds stale row when forwarding
    assign wr_old_set = fwd_hit ? fwd_set : upd_ram_set;

    always_comb begin
        wr_set          = wr_old_set;
        wr_set[wr_lane] = tbc_next(wr_old_set[wr_lane], wr_taken);
    end

    assign wr_byten = {($bits(gbpt_set_t)/8){wr_valid}};

    // --------------------
    // counter array

    bram_2r1w #(
        .WIDTH($bits(gbpt_set_t)),
        .DEPTH(GBPT_SETS)
    ) i_gbpt_ram (
        .CLK          (CLK),
        .nRST         (nRST),
        .port0_ren    (read_req_valid),
        .port0_rindex (rd_index),
        .port0_rdata  (rd_set),
        .port1_ren    (update_valid),
        .port1_rindex (upd_index),
        .port1_rdata  (upd_ram_set),
        .wen_byte     (wr_byten),
        .windex       (wr_index),
        .wdata        (wr_set)
    );

endmodule

//--- hdl/ghr.sv
/*
    global history register
    speculative shift on predictions, restore on mispredict,
    and the history snapshot that travels with each response
*/

`timescale 1ns/100ps

module ghr (
    input  logic                           CLK,
    input  logic                           nRST,

    // prediction request and its response
    input  logic                           req_valid,
    input  logic [bp_pkg::FETCH_LANES-1:0] resp_taken_by_lane,

    // resolution
    input  bp_pkg::update_t                update,

    // current history to the table
    output bp_pkg::gh_t                    gh,

    // delayed request info for the response
    output logic                           resp_valid,
    output bp_pkg::gh_t                    resp_gh
);

    import bp_pkg::*;

    gh_t  gh_next;
    logic restore;
    logic resp_taken;

    // --------------------
    // next history

    assign restore    = update.valid & update.mispredict;
    assign resp_taken = |resp_taken_by_lane;

    // mispredict wins over the speculative shift
    always_comb begin
        gh_next = gh;
        if (restore) begin
            gh_next = {update.gh[GH_BITS-2:0], update.taken};
        end else if (resp_valid) begin
            gh_next = {gh[GH_BITS-2:0], resp_taken};
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            gh <= '0;
        end else begin
            gh <= gh_next;
        end
    end

    // --------------------
    // response snapshot

    // history the table was indexed with, one cycle later
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            resp_valid <= 1'b0;
            resp_gh    <= '0;
        end else begin
            resp_valid <= req_valid;
            resp_gh    <= gh;
        end
    end

endmodule

//--- project.f
hdl/bp_pkg.sv
hdl/bram_2r1w.sv
hdl/gbpt.sv
hdl/ghr.sv
hdl/branch_predictor_top.sv
test/tb_clock.sv
test/bp_assertions.sv
test/tb_branch_predictor.sv

//--- test/bp_assertions.sv
/*
    concurrent checks on the predictor top
    response timing, reset state and mispredict restore of the history
*/

`timescale 1ns/100ps

module bp_assertions (
    input  logic               CLK,
    input  logic               nRST,
    input  bp_pkg::pred_req_t  pred_req,
    input  bp_pkg::pred_resp_t pred_resp,
    input  bp_pkg::update_t    update,
    input  bp_pkg::gh_t        gh
);

    import bp_pkg::*;

    // failed assertions so far
    int fail_count = 0;

    // no response while reset is held
    a_reset_quiet: assert property (@(posedge CLK) !nRST |-> !pred_resp.valid)
        else begin
            fail_count++;
            $error("response valid during reset");
        end

    // --------------------
    // response follows request by one cycle

    a_resp_follows: assert property (@(posedge CLK) disable iff (!nRST)
        pred_req.valid |=> pred_resp.valid)
        else begin
            fail_count++;
            $error("request without response one cycle later");
        end

    a_no_spurious: assert property (@(posedge CLK) disable iff (!nRST)
        !pred_req.valid |=> !pred_resp.valid)
        else begin
            fail_count++;
            $error("response without request one cycle earlier");
        end

    // --------------------
    // mispredict loads history from the update

    a_restore: assert property (@(posedge CLK) disable iff (!nRST)
        (update.valid && update.mispredict)
        |=> gh == (($past(update.gh) << 1) | gh_t'($past(update.taken))))
        else begin
            fail_count++;
            $error("history not restored after mispredict");
        end

endmodule

//--- test/tb_branch_predictor.sv
/*
    directed tests for the branch direction predictor
    cycle model of table and history, compared every cycle against the DUT
*/

`timescale 1ns/100ps

module tb_branch_predictor;

    import bp_pkg::*;

    localparam int CLK_PERIOD      = 40;
    // reset and directed tests take just under 100 cycles
    localparam int DIRECTED_CYCLES = 100;
    localparam int RANDOM_CYCLES   = 300;
    localparam int MARGIN          = 200;
    localparam int WATCHDOG_NS     = (DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN) * CLK_PERIOD;

    logic       CLK;
    logic       nRST;
    asid_t      asid;
    pred_req_t  req;
    pred_resp_t resp;
    update_t    upd;

    // model state
    gbpt_set_t   mdl_mem [GBPT_SETS];
    gh_t         mdl_gh;
    logic        pw_valid;
    gbpt_idx_t   pw_idx;
    fetch_lane_t pw_lane;
    logic        pw_taken;
    logic        exp_valid;
    logic [3:0]  exp_taken;
    gh_t         exp_gh;

    int          errors;
    int          checks;
    int          tests;
    logic [31:0] rng;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) i_clock (.CLK(CLK));

    branch_predictor_top i_dut (
        .CLK       (CLK),
        .nRST      (nRST),
        .arch_asid (asid),
        .pred_req  (req),
        .pred_resp (resp),
        .update    (upd)
    );

    bind branch_predictor_top bp_assertions i_bp_assertions (
        .CLK       (CLK),
        .nRST      (nRST),
        .pred_req  (pred_req),
        .pred_resp (pred_resp),
        .update    (update),
        .gh        (gh)
    );

    // --------------------
    // helpers

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // two-bit counter, {taken, strong}
    function automatic tbc_t counter_step(tbc_t c, logic taken);
        tbc_t n;
        case ({taken, c})
            3'b1_01: n = 2'b00;
            3'b1_00, 3'b1_10, 3'b1_11: n = 2'b11;
            3'b0_11: n = 2'b10;
            default: n = 2'b01;
        endcase
        return n;
    endfunction

    function automatic pred_req_t mk_req(fetch_idx_t fidx);
        pred_req_t r;
        r.valid     = 1'b1;
        r.fetch_idx = fidx;
        return r;
    endfunction

    function automatic update_t mk_upd(fetch_idx_t fidx, fetch_lane_t lane, gh_t hist,
                                       logic taken, logic mispredict);
        update_t u;
        u.valid      = 1'b1;
        u.pc38       = {fidx, lane};
        u.gh         = hist;
        u.taken      = taken;
        u.mispredict = mispredict;
        return u;
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
        end
    endtask

    // one clock cycle: drive, advance the model at the edge, compare
    task automatic step(input pred_req_t r, input update_t u);
        gbpt_idx_t ridx;
        gbpt_set_t rset;
        gh_t       gh_nxt;
        req = r;
        upd = u;
        @(posedge CLK);
        ridx = r.fetch_idx[8:0] ^ mdl_gh ^ asid;
        rset = mdl_mem[ridx];
        if (u.valid && u.mispredict) begin
            gh_nxt = {u.gh[7:0], u.taken};
        end else if (exp_valid) begin
            gh_nxt = {mdl_gh[7:0], |exp_taken};
        end else begin
            gh_nxt = mdl_gh;
        end
        // last cycle's update lands now, in order with this one
        if (pw_valid) begin
            mdl_mem[pw_idx][pw_lane] = counter_step(mdl_mem[pw_idx][pw_lane], pw_taken);
        end
        pw_valid = u.valid;
        pw_idx   = u.pc38[10:2] ^ u.gh ^ asid;
        pw_lane  = u.pc38[1:0];
        pw_taken = u.taken;
        if (r.valid) begin
            for (int l = 0; l < FETCH_LANES; l++) begin
                exp_taken[l] = rset[l][1];
            end
        end
        exp_valid = r.valid;
        exp_gh    = mdl_gh;
        mdl_gh    = gh_nxt;
        #2;
        check(32'(resp.valid), 32'(exp_valid), "response valid");
        if (exp_valid) begin
            check(32'(resp.taken_by_lane), 32'(exp_taken), "taken by lane");
            check(32'(resp.gh), 32'(exp_gh), "response history");
        end
        check(32'(i_dut.gh), 32'(mdl_gh), "global history");
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            step('0, '0);
        end
    endtask

    // set history, read one block, then return the history to zero
    task automatic probe(input fetch_idx_t fidx, input gh_t ugh, input logic ut,
                         output logic [3:0] taken);
        step('0, mk_upd(36'h1FF, 2'd0, ugh, ut, 1'b1));
        step(mk_req(fidx), '0);
        taken = resp.taken_by_lane;
        step('0, '0);
        step('0, mk_upd(36'h1FF, 2'd0, 9'h000, 1'b0, 1'b1));
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %s finished, errors so far %0d", name, errors);
    endtask

    // --------------------
    // tests

    task automatic test_reset();
        for (int i = 0; i < 8; i++) begin
            step(mk_req(36'(i * 37)), '0);
        end
        idle(1);
        check(32'(i_dut.gh), 32'h0, "history after not-taken responses");
        finish_test("reset");
    endtask

    task automatic test_training();
        // row prediction after each update, only lane 2 trained
        logic [3:0] exp_bits [4] = '{4'b0100, 4'b0100, 4'b0000, 4'b0000};
        logic       outcome [4] = '{1'b1, 1'b0, 1'b0, 1'b1};
        logic [3:0] t;
        asid = '0;
        for (int i = 0; i < 4; i++) begin
            step('0, mk_upd(36'h25, 2'd2, 9'h000, outcome[i], 1'b0));
            idle(2);
            probe(36'h25, 9'h000, 1'b0, t);
            check(32'(t), 32'(exp_bits[i]), "trained lane prediction");
        end
        finish_test("training");
    endtask

    task automatic test_forwarding();
        logic [3:0] t;
        step('0, mk_upd(36'h40, 2'd0, 9'h000, 1'b1, 1'b0));
        step('0, mk_upd(36'h40, 2'd1, 9'h000, 1'b1, 1'b0));
        step('0, mk_upd(36'h40, 2'd1, 9'h000, 1'b0, 1'b0));
        step('0, mk_upd(36'h40, 2'd1, 9'h000, 1'b0, 1'b0));
        step('0, mk_upd(36'h40, 2'd3, 9'h000, 1'b1, 1'b0));
        step('0, mk_upd(36'h40, 2'd3, 9'h000, 1'b1, 1'b0));
        idle(2);
        probe(36'h40, 9'h000, 1'b0, t);
        check(32'(t), 32'b1001, "row after back-to-back updates");
        finish_test("forwarding");
    endtask

    task automatic test_hash();
        asid_t      a;
        asid_t      b;
        fetch_idx_t f;
        logic [3:0] t;
        a = 9'h0AB;
        b = 9'h155;
        f = 36'h3_0000_0033;
        asid = a;
        step('0, mk_upd(f, 2'd0, 9'h000, 1'b1, 1'b0));
        idle(2);
        probe(f, 9'h000, 1'b0, t);
        check(32'(t), 32'b0001, "trained row, same ASID");
        asid = b;
        probe(f, 9'h000, 1'b0, t);
        check(32'(t), 32'b0000, "other ASID, other row");
        probe(f ^ 36'(a) ^ 36'(b), 9'h000, 1'b0, t);
        check(32'(t), 32'b0001, "other ASID, aliased row");
        asid = a;
        // history 0x1E0 loaded through a restore
        probe(f, 9'h0F0, 1'b0, t);
        check(32'(t), 32'b0000, "other history, other row");
        probe(f ^ 36'h1E0, 9'h0F0, 1'b0, t);
        check(32'(t), 32'b0001, "other history, aliased row");
        finish_test("hash");
    endtask

    task automatic test_history();
        asid = '0;
        step('0, mk_upd(36'h77, 2'd1, 9'h000, 1'b1, 1'b0));
        idle(2);
        for (int i = 0; i < 4; i++) begin
            step(mk_req(36'h77 ^ 36'(mdl_gh)), '0);
            step('0, '0);
        end
        idle(1);
        check(32'(i_dut.gh), 32'h00F, "history after taken responses");
        // untrained row 0x133, no taken lane
        step(mk_req(36'h133 ^ 36'(mdl_gh)), '0);
        step('0, '0);
        check(32'(i_dut.gh), 32'h01E, "history after a not-taken response");
        // restore beats the shift from a taken response
        step(mk_req(36'h77 ^ 36'(mdl_gh)), '0);
        step('0, mk_upd(36'h1FF, 2'd0, 9'h15A, 1'b1, 1'b1));
        check(32'(i_dut.gh), 32'h0B5, "history after mispredict");
        idle(2);
        finish_test("history");
    endtask

    task automatic test_random();
        pred_req_t r;
        update_t   u;
        logic [31:0] r2;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            rng = xorshift32(rng);
            r2  = xorshift32(rng);
            rng = r2;
            r.valid     = r2[0];
            r.fetch_idx = 36'(r2[28:23]);
            u.valid      = r2[1];
            u.pc38       = 38'(r2[9:2]);
            u.gh         = r2[18:10];
            u.taken      = r2[19];
            u.mispredict = (r2[21:20] == 2'b00);
            asid = 9'(r2[31:29]);
            step(r, u);
        end
        idle(2);
        finish_test("random");
    endtask

    // --------------------
    // watchdog

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

    // --------------------
    // main sequence

    initial begin
        nRST      = 1'b0;
        asid      = '0;
        req       = '0;
        upd       = '0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        rng       = 32'h4b13_fb6c;
        mdl_gh    = '0;
        pw_valid  = 1'b0;
        pw_idx    = '0;
        pw_lane   = '0;
        pw_taken  = 1'b0;
        exp_valid = 1'b0;
        exp_taken = '0;
        exp_gh    = '0;
        for (int i = 0; i < GBPT_SETS; i++) begin
            mdl_mem[i] = '0;
        end
        repeat (5) @(posedge CLK);
        #2;
        nRST = 1'b1;

        test_reset();
        test_training();
        test_forwarding();
        test_hash();
        test_history();
        test_random();

        // failed assertions of the bound checker
        errors += i_dut.i_bp_assertions.fail_count;

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- test/tb_clock.sv
/*
    testbench clock source
    free-running clock, 40 ns period
*/

`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
    end

    always #(PERIOD_NS / 2) CLK = ~CLK;

endmodule
